/* project.f */
src/aesTypesPkg.sv
src/mixModePkg.sv
src/columnMixer.sv
src/columnCollector.sv
src/stateMixer.sv
src/columnSender.sv
src/mixColumnsTop.sv
bench/clockGen.sv
bench/mixColumnsBench.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=mixColumnsBench
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module "$TOP" -f project.f --Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* bench/mixColumnsBench.sv */
`timescale 1ns/1ps
`default_nettype none

module mixColumnsBench
  import aesTypesPkg::*, mixModePkg::*;
();

  localparam int Seed          = 32'hf643;
  localparam int LatencyCycles = 2;    // Fourth strobe to outIndex 0
  localparam int CycleLimit    = 400;  // Tests need under 250 cycles

  logic                        clk;
  logic                        genReset;
  logic                        midReset;
  logic                        dutReset;
  logic                        colValid;
  aesColumn                    colData;
  mixMode                      mode;
  logic                        outValid;
  aesColumn                    outData;
  logic [ColumnIndexWidth-1:0] outIndex;

  aesColumn                    outCols[$];
  logic [ColumnIndexWidth-1:0] outIdx[$];
  int                          outCycles[$];
  int                          inCycles[$];
  aesState                     expStates[$];
  int                          cycleCount = 0;

  assign dutReset = genReset || midReset;

  clockGen clocks (
    .clk  (clk),
    .reset(genReset)
  );

  mixColumnsTop dut (
    .clk     (clk),
    .reset   (dutReset),
    .colValid(colValid),
    .colData (colData),
    .mode    (mode),
    .outValid(outValid),
    .outData (outData),
    .outIndex(outIndex)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic aesColumn columnOf(input aesState st, input int i);
    return st[32*(ColumnsPerState - 1 - i) +: 32];  // Column 0 on top
  endfunction

  function automatic aesColumn modelColumn(input aesColumn col, input mixMode m);
    aesByte     a0, a1, a2, a3;
    aesByte     r0, r1, r2, r3;
    logic [3:0] k0, k1, k2, k3;
    {a0, a1, a2, a3} = col;
    if (m == mixForward) begin
      k0 = 4'h2;
      k1 = 4'h3;
      k2 = 4'h1;
      k3 = 4'h1;
    end else begin
      k0 = 4'he;
      k1 = 4'hb;
      k2 = 4'hd;
      k3 = 4'h9;
    end
    r0 = gfMul(a0, k0) ^ gfMul(a1, k1) ^ gfMul(a2, k2) ^ gfMul(a3, k3);
    r1 = gfMul(a0, k3) ^ gfMul(a1, k0) ^ gfMul(a2, k1) ^ gfMul(a3, k2);
    r2 = gfMul(a0, k2) ^ gfMul(a1, k3) ^ gfMul(a2, k0) ^ gfMul(a3, k1);
    r3 = gfMul(a0, k1) ^ gfMul(a1, k2) ^ gfMul(a2, k3) ^ gfMul(a3, k0);
    return {r0, r1, r2, r3};
  endfunction

  function automatic aesState modelState(input aesState st, input mixMode m);
    aesState result;
    result = '0;
    for (int i = 0; i < ColumnsPerState; i++) begin
      result[32*(ColumnsPerState - 1 - i) +: 32] = modelColumn(columnOf(st, i), m);
    end
    return result;
  endfunction

  function automatic aesState randomState();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitor and timeout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    if (colValid) begin
      inCycles.push_back(cycleCount);  // Strobe as the DUT samples it
    end
    if (outValid) begin
      outCols.push_back(outData);
      outIdx.push_back(outIndex);
      outCycles.push_back(cycleCount);
    end
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Checks failed");
      $fatal(1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic checkColumn(input string testName, input aesColumn expected,
                             input aesColumn actual);
    if (actual !== expected) begin
      reportFailure($sformatf("Error in %s: column expected %h, actual %h",
                              testName, expected, actual));
    end
  endtask

  task automatic checkIndex(input string testName,
                            input logic [ColumnIndexWidth-1:0] expected,
                            input logic [ColumnIndexWidth-1:0] actual);
    if (actual !== expected) begin
      reportFailure($sformatf("Error in %s: outIndex expected %0d, actual %0d",
                              testName, expected, actual));
    end
  endtask

  task automatic checkCycle(input string testName, input int expected, input int actual);
    if (actual != expected) begin
      reportFailure($sformatf("Error in %s: beat cycle expected %0d, actual %0d",
                              testName, expected, actual));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      colValid <= 1'b0;
    end
  endtask

  // Mode goes with column 0; flipMode drives the other mode on columns 1 to 3
  task automatic sendState(input aesState st, input mixMode m, input int maxGap,
                           input bit flipMode);
    mixMode other;
    int     gap;
    other = (m == mixForward) ? mixInverse : mixForward;
    for (int c = 0; c < ColumnsPerState; c++) begin
      @(posedge clk);
      colValid <= 1'b1;
      colData  <= columnOf(st, c);
      mode     <= (c == 0 || !flipMode) ? m : other;
      if (c < ColumnsPerState - 1 && maxGap > 0) begin
        gap = $urandom_range(maxGap, 0);
        idleCycles(gap);
      end
    end
    expStates.push_back(modelState(st, m));
  endtask

  // Waits for four beats and checks order, timing and data against the model
  task automatic receiveState(input string testName, output aesState got);
    aesState                     expected;
    aesColumn                    col;
    logic [ColumnIndexWidth-1:0] idx;
    int                          cyc;
    int                          strobeCycle;
    while (outCols.size() < ColumnsPerState) @(posedge clk);
    if (inCycles.size() < ColumnsPerState || expStates.size() == 0) begin
      reportFailure($sformatf("%s: output columns arrived without a full input state",
                              testName));
    end
    strobeCycle = 0;
    for (int s = 0; s < ColumnsPerState; s++) begin
      strobeCycle = inCycles.pop_front();  // Keeps the fourth strobe
    end
    expected = expStates.pop_front();
    got = '0;
    for (int i = 0; i < ColumnsPerState; i++) begin
      col = outCols.pop_front();
      idx = outIdx.pop_front();
      cyc = outCycles.pop_front();
      checkIndex(testName, ColumnIndexWidth'(i), idx);
      checkCycle(testName, strobeCycle + LatencyCycles + i, cyc);
      checkColumn(testName, columnOf(expected, i), col);
      got[32*(ColumnsPerState - 1 - i) +: 32] = col;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic knownColumnTest();
    aesState known;
    aesState knownMixed;
    aesState got;
    aesState back;
    known      = {32'hdb135345, 32'hf20a225c, 32'hd4d4d4d5, 32'h2d26314c};
    knownMixed = {32'h8e4da1bc, 32'h9fdc589d, 32'hd5d5d7d6, 32'h4d7ebdf8};
    sendState(known, mixForward, 0, 1'b0);
    idleCycles(1);
    receiveState("knownForward", got);
    for (int i = 0; i < ColumnsPerState; i++) begin
      checkColumn("knownForward", columnOf(knownMixed, i), columnOf(got, i));
    end
    sendState(got, mixInverse, 0, 1'b0);
    idleCycles(1);
    receiveState("knownInverse", back);
    for (int i = 0; i < ColumnsPerState; i++) begin
      checkColumn("knownInverse", columnOf(known, i), columnOf(back, i));
    end
  endtask

  task automatic roundTripTest();
    aesState st;
    aesState got;
    aesState back;
    for (int n = 0; n < 3; n++) begin
      st = randomState();
      sendState(st, mixForward, 0, 1'b0);
      idleCycles(1);
      receiveState("roundTripForward", got);
      sendState(got, mixInverse, 0, 1'b0);
      idleCycles(1);
      receiveState("roundTripInverse", back);
      for (int i = 0; i < ColumnsPerState; i++) begin
        checkColumn("roundTrip", columnOf(st, i), columnOf(back, i));
      end
    end
  endtask

  task automatic timingTest();
    aesState got;
    sendState(randomState(), mixForward, 0, 1'b0);
    idleCycles(1);
    receiveState("timing", got);
    idleCycles(3);
    if (outCols.size() != 0) begin
      reportFailure("timing: outValid stayed high after column 3");
    end
  endtask

  task automatic modePerStateTest();
    aesState got;
    for (int n = 0; n < 6; n++) begin
      sendState(randomState(), (n % 2 == 0) ? mixForward : mixInverse, 0, 1'b1);
    end
    idleCycles(1);
    for (int n = 0; n < 6; n++) begin
      receiveState("modePerState", got);
    end
  endtask

  task automatic gapTest();
    aesState got;
    for (int n = 0; n < 3; n++) begin
      sendState(randomState(), (n % 2 == 0) ? mixInverse : mixForward, 3, 1'b0);
      idleCycles($urandom_range(2, 1));
    end
    for (int n = 0; n < 3; n++) begin
      receiveState("gaps", got);
    end
  endtask

  task automatic resetTest();
    aesState partial;
    aesState got;
    partial = randomState();
    @(posedge clk);
    colValid <= 1'b1;
    colData  <= columnOf(partial, 0);
    mode     <= mixInverse;  // Would stick if the partial state survived
    @(posedge clk);
    colData  <= columnOf(partial, 1);
    @(posedge clk);
    colValid <= 1'b0;
    midReset <= 1'b1;
    repeat (2) @(posedge clk);
    midReset <= 1'b0;
    idleCycles(4);
    if (outCols.size() != 0) begin
      reportFailure("resetMidState: outValid went high after a reset mid-state");
    end
    inCycles.delete();  // Strobes of the discarded columns
    sendState(randomState(), mixForward, 0, 1'b1);
    idleCycles(1);
    receiveState("resetMidState", got);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    void'($urandom(Seed));
    colValid <= 1'b0;
    colData  <= '0;
    mode     <= mixForward;
    midReset <= 1'b0;
    @(posedge clk);
    while (genReset) @(posedge clk);
    knownColumnTest();
    roundTripTest();
    timingTest();
    modePerStateTest();
    gapTest();
    resetTest();
    idleCycles(2);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;  // Released after three rising edges
  end

endmodule

`default_nettype wire

/* src/mixColumnsTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mixColumnsTop
  import aesTypesPkg::*, mixModePkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   colValid,
  input  aesColumn                    colData,
  input  mixMode                      mode,
  output logic                        outValid,
  output aesColumn                    outData,
  output logic [ColumnIndexWidth-1:0] outIndex
);

  logic    stateValid;
  aesState stateData;
  mixMode  stateMode;
  logic    mixedValid;
  aesState mixedData;

  columnCollector collector (
    .clk       (clk),
    .reset     (reset),
    .colValid  (colValid),
    .colData   (colData),
    .mode      (mode),
    .stateValid(stateValid),
    .stateData (stateData),
    .stateMode (stateMode)
  );

  stateMixer mixer (
    .clk       (clk),
    .reset     (reset),
    .stateValid(stateValid),
    .stateData (stateData),
    .stateMode (stateMode),
    .mixedValid(mixedValid),
    .mixedData (mixedData)
  );

  columnSender sender (
    .clk       (clk),
    .reset     (reset),
    .mixedValid(mixedValid),
    .mixedData (mixedData),
    .outValid  (outValid),
    .outData   (outData),
    .outIndex  (outIndex)
  );

endmodule

`default_nettype wire

/* src/columnSender.sv */
`timescale 1ns/1ps
`default_nettype none

module columnSender
  import aesTypesPkg::*, mixModePkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   mixedValid,
  input  aesState                     mixedData,
  output logic                        outValid,
  output aesColumn                    outData,
  output logic [ColumnIndexWidth-1:0] outIndex
);

  aesState                     holdData;   // Columns not yet sent with the next one on top
  logic [ColumnIndexWidth-1:0] beatIndex;  // Index of the next registered beat
  logic                        busy;
  logic                        lastBeat;

  assign lastBeat = beatIndex == ColumnIndexWidth'(ColumnsPerState - 1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      beatIndex <= '0;
    end else if (mixedValid) begin
      busy      <= 1'b1;  // Column 0 goes out now and 1 to 3 follow
      beatIndex <= ColumnIndexWidth'(1);
    end else if (busy) begin
      beatIndex <= beatIndex + 1'b1;
      if (lastBeat) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mixedValid) begin
      holdData <= {mixedData[95:0], 32'h0};  // Column 0 bypasses the register
    end else if (busy) begin
      holdData <= {holdData[95:0], 32'h0};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign outValid = mixedValid || busy;
  assign outIndex = mixedValid ? '0 : beatIndex;
  assign outData  = mixedValid ? mixedData[127:96] : holdData[127:96];

  // Beats after column 0 come on consecutive cycles and count up to column 3
  aNoWrap : assert property (
    @(posedge clk) disable iff (reset)
    (outValid && !mixedValid)
      |-> $past(outValid) && outIndex != '0 && outIndex == $past(outIndex) + 1'b1
  ) else $error("columnSender: outIndex wrapped within a state");

  // Input spacing of four cycles per state keeps loads off running beats
  aLoadWhenFree : assert property (
    @(posedge clk) disable iff (reset)
    mixedValid |-> !busy
  ) else $error("columnSender: new state while columns are still pending");

endmodule

`default_nettype wire

/* src/stateMixer.sv */
`timescale 1ns/1ps
`default_nettype none

module stateMixer
  import aesTypesPkg::*, mixModePkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic stateValid,
  input  aesState   stateData,
  input  mixMode    stateMode,
  output logic      mixedValid,
  output aesState   mixedData
);

  aesState mixedAll;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Four columns in parallel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar j = 0; j < ColumnsPerState; j++) begin : gColumn
    columnMixer mixer (
      .column(stateData[32*(ColumnsPerState - 1 - j) +: 32]),  // Column 0 on top
      .mode  (stateMode),
      .mixed (mixedAll[32*(ColumnsPerState - 1 - j) +: 32])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      mixedValid <= 1'b0;
    end else begin
      mixedValid <= stateValid;  // One cycle through the mixer
    end
  end

  always_ff @(posedge clk) begin
    if (stateValid) begin
      mixedData <= mixedAll;  // Held until the next state
    end
  end

endmodule

`default_nettype wire

/* src/columnCollector.sv */
`timescale 1ns/1ps
`default_nettype none

module columnCollector
  import aesTypesPkg::*, mixModePkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic colValid,
  input  aesColumn  colData,
  input  mixMode    mode,
  output logic      stateValid,
  output aesState   stateData,
  output mixMode    stateMode
);

  logic [ColumnIndexWidth-1:0] colIndex;
  logic lastColumn;

  assign lastColumn = colIndex == ColumnIndexWidth'(ColumnsPerState - 1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Column count and state strobe
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      colIndex   <= '0;  // Partial state is dropped
      stateValid <= 1'b0;
    end else begin
      stateValid <= colValid && lastColumn;  // Pulse after fourth column
      if (colValid) begin
        colIndex <= colIndex + 1'b1;  // Wraps to 0 after column 3
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State and mode capture
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (colValid) begin
      stateData <= {stateData[95:0], colData};  // First column ends up on top
      if (colIndex == '0) begin
        stateMode <= mode;  // Mode is taken with column 0 only
      end
    end
  end

  // The strobe comes one cycle after column 3, so the count has wrapped
  aIndexAtState : assert property (
    @(posedge clk) disable iff (reset)
    stateValid |-> colIndex == '0
  ) else $error("columnCollector: stateValid with a partial column count");

endmodule

`default_nettype wire

/* src/columnMixer.sv */
`timescale 1ns/1ps
`default_nettype none

module columnMixer
  import aesTypesPkg::*, mixModePkg::*;
(
  input  aesColumn column,
  input  mixMode   mode,
  output aesColumn mixed
);

  aesByte     rowIn [4];
  logic [3:0] coef  [4];  // First row of the circulant matrix

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Matrix selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (mode == mixInverse) begin
      coef = '{4'he, 4'hb, 4'hd, 4'h9};  // InvMixColumns
    end else begin
      coef = '{4'h2, 4'h3, 4'h1, 4'h1};  // MixColumns
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rowIn[2'(i)] = column[8*(3 - i) +: 8];  // Row 0 sits in 31:24
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row products
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Each row is the row above rotated right by one byte, so row r
  // takes coefficient (c - r) mod 4 for input byte c
  always_comb begin
    aesByte acc;
    mixed = '0;
    for (int r = 0; r < 4; r++) begin
      acc = '0;
      for (int c = 0; c < 4; c++) begin
        acc = acc ^ gfMul(rowIn[2'(c)], coef[2'(c - r)]);
      end
      mixed[8*(3 - r) +: 8] = acc;
    end
  end

endmodule

`default_nettype wire

/* src/mixModePkg.sv */
`default_nettype none

package mixModePkg;

  typedef enum logic {
    mixForward = 1'b0,  // MixColumns
    mixInverse = 1'b1   // InvMixColumns
  } mixMode;

  localparam int ColumnsPerState = 4;
  localparam int ColumnIndexWidth = 2;  // Column index 0 to 3

endpackage

`default_nettype wire

/* src/aesTypesPkg.sv */
`default_nettype none

package aesTypesPkg;

  typedef logic [7:0]   aesByte;    // One GF(2^8) element
  typedef logic [31:0]  aesColumn;  // Row 0 in bits 31:24
  typedef logic [127:0] aesState;   // Column 0 in bits 127:96

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // GF(2^8) arithmetic, polynomial 0x11B
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic aesByte gfXtime(input aesByte a);
    aesByte shifted;
    shifted = {a[6:0], 1'b0};
    return a[7] ? (shifted ^ 8'h1b) : shifted;  // Reduce on carry out
  endfunction

  // Product with a 4-bit constant, enough for 1,2,3,9,b,d,e
  function automatic aesByte gfMul(input aesByte a, input logic [3:0] k);
    aesByte acc;
    aesByte pow;
    acc = '0;
    pow = a;
    for (int i = 0; i < 4; i++) begin
      if (k[i]) begin
        acc = acc ^ pow;  // Add a * 2^i
      end
      pow = gfXtime(pow);
    end
    return acc;
  endfunction

endpackage

`default_nettype wire
